// File: cop_unit.f
verilog/cop_pkg.sv
verilog/cop_rf_if.sv
verilog/cop_pipe_ctl.sv
verilog/cop_reg_file.sv
verilog/cop_unit.sv
dv/cop_unit_tb.sv

// File: dv/cop_unit_tb.sv
`timescale 1ns/1ps

module cop_unit_tb import cop_pkg::*; ();

  localparam logic [1:0] COP_SEL      = 2'd2;
  localparam int         NUM_ROWS     = 44;
  localparam int         RESET_CYCLES = 8;
  localparam int         RUN_LIMIT    = NUM_ROWS + RESET_CYCLES + 20;

  typedef enum int {NOP, MF, CF, MT, CT, LWC, SWC} op_e;

  typedef struct {
    string      name;
    op_e        op;
    reg_addr_t  addr;
    logic [1:0] cop;
    logic       m32;
    word_t      instr;
    word_t      data;
    logic       exc;
    logic       hold;
    logic       exp_drv;
    logic       exp_mem;
    word_t      exp_rd;
    logic       exp_cond;
  } row_t;

  // Model pipeline slot where wr 1 means general and 2 means control
  typedef struct packed {
    logic [1:0] wr;
    reg_addr_t  addr;
    word_t      data;
    logic       drv;
    logic       mem;
    word_t      val;
  } stage_t;

  logic        SYSCLK;
  logic        rst;
  logic [31:0] instr_s;
  logic        m32_s;
  logic        hold;
  logic        dload;
  logic        exception;
  logic [31:0] idbus_in;
  logic        cond_n_r;
  logic        memop_m;
  logic        drv_m;
  logic [31:0] rd_data_m;

  row_t   rows [NUM_ROWS];
  int     row_count   = 0;
  integer seed        = 91335;
  int     checks      = 0;
  int     errors      = 0;
  int     cycle_count = 0;

  cop_unit #(.COP_NUM(COP_SEL)) dut (
    .SYSCLK    (SYSCLK),
    .rst       (rst),
    .instr_s   (instr_s),
    .m32_s     (m32_s),
    .hold      (hold),
    .dload     (dload),
    .exception (exception),
    .idbus_in  (idbus_in),
    .cond_n_r  (cond_n_r),
    .memop_m   (memop_m),
    .drv_m     (drv_m),
    .rd_data_m (rd_data_m)
  );

  initial begin
    SYSCLK = 1'b0;
    forever #20 SYSCLK = ~SYSCLK;
  end

  task automatic add_row(input string name, input op_e op, input reg_addr_t addr,
                         input logic [1:0] cop, input logic m32, input logic exc,
                         input logic hold_in);
    row_t       r;
    logic [4:0] sub;
    r.name = name;
    r.op   = op;
    r.addr = addr;
    r.cop  = cop;
    r.m32  = m32;
    r.exc  = exc;
    r.hold = hold_in;
    r.data = $random(seed);
    r.exp_drv  = 1'b0;
    r.exp_mem  = 1'b0;
    r.exp_rd   = '0;
    r.exp_cond = 1'b0;
    sub = (op == CF) ? SUB_CF : (op == MT) ? SUB_MT : (op == CT) ? SUB_CT : SUB_MF;
    case (op)
      LWC:     r.instr = {OP_LWC_HI, cop, 5'd4, addr, 16'h0010};
      SWC:     r.instr = {OP_SWC_HI, cop, 5'd4, addr, 16'h0020};
      NOP:     r.instr = '0;
      default: r.instr = {OP_COP_HI, cop, sub, 5'd1, addr, 11'd0};
    endcase
    rows[row_count] = r;
    row_count++;
  endtask

  task automatic add_op(input string name, input op_e op, input reg_addr_t addr);
    add_row(name, op, addr, COP_SEL, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic add_idle(input string name, input int count, input logic hold_in);
    for (int k = 0; k < count; k++) begin
      add_row(name, NOP, 5'd0, COP_SEL, 1'b1, 1'b0, hold_in);
    end
  endtask

  task automatic build_table();
    add_op("mt_far", MT, 5'd3);
    add_idle("idle_far", 3, 1'b0);
    add_op("mf_far", MF, 5'd3);        // Four slots after the MT
    add_op("ct_far", CT, 5'd3);
    add_idle("idle_ct", 3, 1'b0);
    add_op("cf_far", CF, 5'd3);
    add_op("mf_separate", MF, 5'd3);   // General r3 untouched by the CT
    add_op("mt_near", MT, 5'd7);
    add_idle("idle_near", 1, 1'b0);
    add_op("mf_bypass", MF, 5'd7);
    add_op("mf_write_first", MF, 5'd7);
    add_op("lwc", LWC, 5'd9);
    add_idle("idle_lwc", 3, 1'b0);
    add_op("swc", SWC, 5'd9);
    add_op("mt_squashed", MT, 5'd3);
    add_row("exception", NOP, 5'd0, COP_SEL, 1'b1, 1'b1, 1'b0);
    add_idle("idle_exc", 2, 1'b0);
    add_op("mf_old_value", MF, 5'd3);
    add_op("mf_before_hold", MF, 5'd7);
    add_idle("hold", 3, 1'b1);
    add_op("mf_after_hold", MF, 5'd9);
    add_idle("idle_hold", 2, 1'b0);
    add_op("ct_cond_set", CT, COND_REG);
    rows[row_count - 1].data[0] = 1'b1;
    add_row("mt_other_cop", MT, 5'd5, 2'd1, 1'b1, 1'b0, 1'b0);
    add_row("mt_m32_low", MT, 5'd5, COP_SEL, 1'b0, 1'b0, 1'b0);
    add_idle("idle_other", 1, 1'b0);
    add_op("mf_unwritten", MF, 5'd5);
    add_row("mf_other_cop", MF, 5'd5, 2'd3, 1'b1, 1'b0, 1'b0);
    add_row("mf_m32_low", MF, 5'd5, COP_SEL, 1'b0, 1'b0, 1'b0);
    add_idle("idle_cond", 1, 1'b0);
    add_op("ct_cond_clear", CT, COND_REG);
    rows[row_count - 1].data[0] = 1'b0;
    add_idle("drain", 3, 1'b0);
  endtask

  // Reference model that gives each row the outputs seen two cycles later
  task automatic build_expected();
    word_t      gen_sh [32];
    word_t      con_sh [32];
    row_t       r;
    stage_t     e_st = '0;
    stage_t     m_st = '0;
    stage_t     w_st = '0;
    stage_t     i_st;
    logic [1:0] rd_cls;
    logic       valid;
    logic       cond_q = 1'b0;
    for (int k = 0; k < 32; k++) begin
      gen_sh[k] = '0;
      con_sh[k] = '0;
    end
    for (int c = 0; c < NUM_ROWS + 2; c++) begin
      if (c < NUM_ROWS) begin
        r = rows[c];
      end else begin
        r.op   = NOP;
        r.exc  = 1'b0;
        r.hold = 1'b0;
      end
      if (c >= 2) begin
        rows[c - 2].exp_drv  = m_st.drv;
        rows[c - 2].exp_mem  = m_st.mem;
        rows[c - 2].exp_rd   = m_st.val;
        rows[c - 2].exp_cond = cond_q;
      end
      cond_q = ~con_sh[COND_REG][0];   // Registered at the next edge
      if (!r.hold) begin
        if (w_st.wr == 2'd1) gen_sh[w_st.addr] = w_st.data;
        if (w_st.wr == 2'd2) con_sh[w_st.addr] = w_st.data;
        valid     = r.m32 && (r.cop == COP_SEL) && (r.op != NOP);
        i_st.wr   = !valid ? 2'd0 : (r.op == MT || r.op == LWC) ? 2'd1 :
                    (r.op == CT) ? 2'd2 : 2'd0;
        rd_cls    = !valid ? 2'd0 : (r.op == MF || r.op == SWC) ? 2'd1 :
                    (r.op == CF) ? 2'd2 : 2'd0;
        i_st.drv  = rd_cls != 2'd0;
        i_st.mem  = valid && (r.op == LWC || r.op == SWC);
        i_st.addr = r.addr;
        i_st.data = r.data;
        i_st.val  = (rd_cls == 2'd2) ? con_sh[r.addr] : gen_sh[r.addr];
        if (rd_cls != 2'd0 && m_st.wr == rd_cls && m_st.addr == r.addr) begin
          i_st.val = m_st.data;          // Write two slots back
        end
        if (r.exc) begin
          i_st.wr = 2'd0;
          e_st.wr = 2'd0;
          m_st.wr = 2'd0;
        end
        w_st = m_st;
        m_st = e_st;
        e_st = i_st;
      end
    end
  endtask

  task automatic check_value(input string test, input string sig,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    a_value: assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test, sig, expected, actual);
    end
  endtask

  task automatic check_row(input row_t r);
    check_value(r.name, "drv_m", 32'(r.exp_drv), 32'(drv_m));
    check_value(r.name, "memop_m", 32'(r.exp_mem), 32'(memop_m));
    check_value(r.name, "cond_n_r", 32'(r.exp_cond), 32'(cond_n_r));
    if (r.exp_drv) begin
      check_value(r.name, "rd_data_m", r.exp_rd, rd_data_m);
    end
  endtask

  task automatic apply_cycle(input int c);
    if (c < NUM_ROWS) begin
      instr_s   = rows[c].instr;
      m32_s     = rows[c].m32;
      exception = rows[c].exc;
      hold      = rows[c].hold;
    end else begin
      instr_s   = '0;
      m32_s     = 1'b0;
      exception = 1'b0;
      hold      = 1'b0;
    end
    idbus_in = (c >= 2) ? rows[c - 2].data : '0;  // Bus data trails by two rows
  endtask

  always @(posedge SYSCLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= RUN_LIMIT) begin
      $display("Timeout, the run did not finish within %0d cycles", RUN_LIMIT);
      $display("Summary: %0d checks, %0d errors, 1 timeout", checks, errors);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    rst       = 1'b1;
    instr_s   = '0;
    m32_s     = 1'b0;
    hold      = 1'b0;
    dload     = 1'b0;
    exception = 1'b0;
    idbus_in  = '0;
    build_table();
    if (row_count != NUM_ROWS) begin
      errors++;
      $display("Stimulus table holds %0d rows instead of %0d", row_count, NUM_ROWS);
    end
    build_expected();
    repeat (RESET_CYCLES) @(posedge SYSCLK);
    #1;
    rst = 1'b0;
    for (int c = 0; c < NUM_ROWS + 2; c++) begin
      if (c > 0) begin
        @(posedge SYSCLK);
        #1;
      end
      apply_cycle(c);
      #19;
      if (c == 0) begin
        check_value("reset", "drv_m", 32'd0, 32'(drv_m));
        check_value("reset", "memop_m", 32'd0, 32'(memop_m));
        check_value("reset", "cond_n_r", 32'd0, 32'(cond_n_r));
        check_value("reset", "rd_data_m", 32'd0, rd_data_m);
        check_value("reset", "wr_gen_wr_con", 32'd0,
                    32'({dut.rf_bus.wr_gen, dut.rf_bus.wr_con}));
      end else if (c >= 2) begin
        check_row(rows[c - 2]);
      end
    end
    $display("Summary: %0d checks, %0d errors, 0 timeouts", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cop_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps \
  --top-module cop_unit_tb -f cop_unit.f -o cop_unit_sim

./obj_dir/cop_unit_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

// File: verilog/cop_pipe_ctl.sv
`timescale 1ns/1ps

module cop_pipe_ctl import cop_pkg::*; #(
  parameter logic [1:0] COP_NUM = 2'd2
) (
  input  logic       SYSCLK,
  input  logic       rst,
  input  cop_instr_t instr_s,
  input  logic       m32_s,
  input  logic       hold,
  input  logic       dload,
  input  logic       exception,
  input  word_t      idbus_in,
  cop_rf_if.ctl      rf,
  output logic       cond_n_r,
  output logic       memop_m,
  output logic       drv_m,
  output word_t      rd_data_m
);

  localparam logic [5:0] OPC_COP = {OP_COP_HI, COP_NUM};
  localparam logic [5:0] OPC_LWC = {OP_LWC_HI, COP_NUM};
  localparam logic [5:0] OPC_SWC = {OP_SWC_HI, COP_NUM};

  reg_addr_t addr_p;
  logic      rd_gen_p;
  logic      rd_con_p;
  logic      wr_gen_p;
  logic      wr_con_p;
  logic      memop_p;
  logic      drv_p;
  logic      rdsel_p;

  reg_addr_t wr_addr_e;
  reg_addr_t wr_addr_m;
  logic      wr_gen_e;
  logic      wr_con_e;
  logic      wr_gen_m;
  logic      wr_con_m;
  logic      memop_e;
  logic      drv_e;
  logic      rdsel_e;
  logic      exc_r;

  // Issue stage decode
  always_comb begin
    addr_p   = '0;
    rd_gen_p = 1'b0;
    rd_con_p = 1'b0;
    wr_gen_p = 1'b0;
    wr_con_p = 1'b0;
    memop_p  = 1'b0;
    drv_p    = 1'b0;
    rdsel_p  = 1'b0;
    if (m32_s) begin
      case (instr_s.mv.opcode)
        OPC_COP: begin
          addr_p = instr_s.mv.rd;
          case (instr_s.mv.sub_op)
            SUB_MF: begin
              drv_p    = 1'b1;
              rdsel_p  = (addr_p == wr_addr_m) && wr_gen_m;  // Write two slots back
              rd_gen_p = !rdsel_p;
            end
            SUB_CF: begin
              drv_p    = 1'b1;
              rdsel_p  = (addr_p == wr_addr_m) && wr_con_m;
              rd_con_p = !rdsel_p;
            end
            SUB_MT:  wr_gen_p = 1'b1;
            SUB_CT:  wr_con_p = 1'b1;
            default: addr_p = '0;
          endcase
        end
        OPC_LWC: begin
          addr_p   = instr_s.mem.rt;
          memop_p  = 1'b1;
          wr_gen_p = 1'b1;
        end
        OPC_SWC: begin
          addr_p   = instr_s.mem.rt;
          memop_p  = 1'b1;
          drv_p    = 1'b1;
          rdsel_p  = (addr_p == wr_addr_m) && wr_gen_m;
          rd_gen_p = !rdsel_p;
        end
        default: addr_p = '0;
      endcase
    end
  end

  // A stalled issue slot re-reads once hold drops
  assign rf.rd_addr = addr_p;
  assign rf.rd_gen  = rd_gen_p && !hold;
  assign rf.rd_con  = rd_con_p && !hold;

  always_ff @(posedge SYSCLK) begin
    if (rst) begin
      wr_gen_e  <= 1'b0;
      wr_con_e  <= 1'b0;
      wr_gen_m  <= 1'b0;
      wr_con_m  <= 1'b0;
      rf.wr_gen <= 1'b0;
      rf.wr_con <= 1'b0;
    end else if (!hold) begin
      wr_gen_e  <= wr_gen_p && !exception;  // Squash all in-flight writes
      wr_con_e  <= wr_con_p && !exception;
      wr_gen_m  <= wr_gen_e && !exception;
      wr_con_m  <= wr_con_e && !exception;
      rf.wr_gen <= wr_gen_m && !exception;
      rf.wr_con <= wr_con_m && !exception;
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (!hold) begin
      wr_addr_e  <= addr_p;
      wr_addr_m  <= wr_addr_e;
      rf.wr_addr <= wr_addr_m;
    end
  end

  // Bus data arrives in M and is written from W
  always_ff @(posedge SYSCLK) begin
    if (dload || !hold) begin
      rf.wr_data <= idbus_in;
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (rst) begin
      rdsel_e   <= 1'b0;
      drv_e     <= 1'b0;
      drv_m     <= 1'b0;
      memop_e   <= 1'b0;
      memop_m   <= 1'b0;
      rd_data_m <= '0;
    end else if (!hold) begin
      rdsel_e   <= rdsel_p && !exc_r;
      drv_e     <= drv_p;
      drv_m     <= drv_e;
      memop_e   <= memop_p;
      memop_m   <= memop_e;
      rd_data_m <= rdsel_e ? rf.wr_data : rf.rd_data;
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (rst) begin
      exc_r    <= 1'b0;
      cond_n_r <= 1'b0;
    end else begin
      exc_r    <= exception;
      cond_n_r <= rf.cond_n;
    end
  end

  a_wr_class_onehot: assert property (@(posedge SYSCLK) disable iff (rst)
    !(rf.wr_gen && rf.wr_con));

  // A read and a write never share one instruction
  a_drv_no_write: assert property (@(posedge SYSCLK) disable iff (rst)
    drv_m |-> !(wr_gen_m || wr_con_m));

endmodule

// File: verilog/cop_pkg.sv
package cop_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  localparam logic [3:0] OP_COP_HI = 4'b0100;
  localparam logic [3:0] OP_LWC_HI = 4'b1100;
  localparam logic [3:0] OP_SWC_HI = 4'b1110;

  localparam logic [4:0] SUB_MF = 5'b00000;
  localparam logic [4:0] SUB_CF = 5'b00010;
  localparam logic [4:0] SUB_MT = 5'b00100;
  localparam logic [4:0] SUB_CT = 5'b00110;

  localparam reg_addr_t COND_REG = 5'd31;  // Bit 0 is the condition

  // Register move form for MF MT CF CT
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  sub_op;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [10:0] unused;
  } cop_mv_t;

  // Load and store form for LWC SWC
  typedef struct packed {
    logic [5:0]  opcode;
    reg_addr_t   base;
    reg_addr_t   rt;
    logic [15:0] offset;
  } cop_mem_t;

  typedef union packed {
    cop_mv_t  mv;
    cop_mem_t mem;
  } cop_instr_t;

endpackage

// File: verilog/cop_reg_file.sv
`timescale 1ns/1ps

module cop_reg_file import cop_pkg::*; (
  input logic   SYSCLK,
  input logic   rst,
  cop_rf_if.rf  rf
);

  localparam int NUM_REGS = 32;

  word_t gen_regs [NUM_REGS];
  word_t con_regs [NUM_REGS];

  logic  fwd_gen;
  logic  fwd_con;

  always_ff @(posedge SYSCLK) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        gen_regs[i] <= '0;
        con_regs[i] <= '0;
      end
    end else if (rf.wr_gen) begin
      gen_regs[rf.wr_addr] <= rf.wr_data;
    end else if (rf.wr_con) begin
      con_regs[rf.wr_addr] <= rf.wr_data;
    end
  end

  // Same-edge write wins over the array
  assign fwd_gen = rf.wr_gen && (rf.wr_addr == rf.rd_addr);
  assign fwd_con = rf.wr_con && (rf.wr_addr == rf.rd_addr);

  always_ff @(posedge SYSCLK) begin
    if (rf.rd_gen) begin
      if (fwd_gen) begin
        rf.rd_data <= rf.wr_data;
      end else begin
        rf.rd_data <= gen_regs[rf.rd_addr];
      end
    end else if (rf.rd_con) begin
      if (fwd_con) begin
        rf.rd_data <= rf.wr_data;
      end else begin
        rf.rd_data <= con_regs[rf.rd_addr];
      end
    end
  end

  assign rf.cond_n = ~con_regs[COND_REG][0];

  a_rd_class_onehot: assert property (@(posedge SYSCLK) disable iff (rst)
    !(rf.rd_gen && rf.rd_con));

endmodule

// File: verilog/cop_rf_if.sv
`timescale 1ns/1ps

interface cop_rf_if import cop_pkg::*; ();

  reg_addr_t rd_addr;
  logic      rd_gen;
  logic      rd_con;
  word_t     rd_data;  // Valid one cycle after request

  reg_addr_t wr_addr;
  logic      wr_gen;
  logic      wr_con;
  word_t     wr_data;

  logic      cond_n;

  modport ctl (
    output rd_addr, rd_gen, rd_con,
    output wr_addr, wr_gen, wr_con, wr_data,
    input  rd_data, cond_n
  );

  modport rf (
    input  rd_addr, rd_gen, rd_con,
    input  wr_addr, wr_gen, wr_con, wr_data,
    output rd_data, cond_n
  );

endinterface

// File: verilog/cop_unit.sv
`timescale 1ns/1ps

module cop_unit #(
  parameter logic [1:0] COP_NUM = 2'd2  // Low opcode bits
) (
  input  logic        SYSCLK,
  input  logic        rst,
  input  logic [31:0] instr_s,
  input  logic        m32_s,
  input  logic        hold,
  input  logic        dload,
  input  logic        exception,
  input  logic [31:0] idbus_in,
  output logic        cond_n_r,
  output logic        memop_m,
  output logic        drv_m,
  output logic [31:0] rd_data_m
);

  cop_rf_if rf_bus ();

  cop_pipe_ctl #(
    .COP_NUM   (COP_NUM)
  ) u_pipe_ctl (
    .SYSCLK    (SYSCLK),
    .rst       (rst),
    .instr_s   (instr_s),
    .m32_s     (m32_s),
    .hold      (hold),
    .dload     (dload),
    .exception (exception),
    .idbus_in  (idbus_in),
    .rf        (rf_bus.ctl),
    .cond_n_r  (cond_n_r),
    .memop_m   (memop_m),
    .drv_m     (drv_m),
    .rd_data_m (rd_data_m)
  );

  cop_reg_file u_reg_file (
    .SYSCLK    (SYSCLK),
    .rst       (rst),
    .rf        (rf_bus.rf)
  );

endmodule
